// File: hdl/mod47_macros.svh
`ifndef MOD47_MACROS_SVH
`define MOD47_MACROS_SVH

// ------------------------------------------------
// Block and lane geometry
// ------------------------------------------------
`define MOD47_BLOCK_W 100
`define MOD47_LANE_W 25
`define MOD47_LANES 4

// Width of the num_blocks input.
`define MOD47_CNT_W 8

// ------------------------------------------------
// Arithmetic constants
// ------------------------------------------------
`define MOD47_MODULUS 47
`define MOD47_FOLD_MUL 21 // 2^100 mod 47.

`endif

// File: hdl/mod47_pkg.sv
`include "mod47_macros.svh"

package mod47_pkg;

  typedef logic [5:0] residue_t; // Always below 47.

  // 100-bit block cut into 6-bit digits from the bottom.
  typedef struct packed {
    logic [3:0]       top;
    logic [14:0][5:0] mid;
    logic [5:0]       low;
  } block_digits_t;

  typedef logic [`MOD47_LANES-1:0][`MOD47_LANE_W-1:0] block_lanes_t;

  typedef union packed {
    block_lanes_t  lanes;  // Lane 0 is least significant.
    block_digits_t digits;
  } block_t;

  typedef enum logic [1:0] {
    st_idle,
    st_collect,
    st_finish
  } fsm_state_t;

  // Reduce a value below 1024 to its residue mod 47.
  function automatic residue_t fold_mod47(input logic [9:0] value);
    logic [7:0] part1;
    logic [6:0] part2;
    part1 = 8'(value[5:0]) + 8'(value[7:6]) * 8'd17 + 8'(value[9:8]) * 8'd21; // 64=17, 256=21.
    part2 = 7'(part1[5:0]) + 7'(part1[7:6]) * 7'd17; // At most 83 here.
    if (part2 >= 7'(`MOD47_MODULUS))
      return residue_t'(part2 - 7'(`MOD47_MODULUS));
    return residue_t'(part2);
  endfunction

endpackage

// File: hdl/mod47_ctl_if.sv
interface mod47_ctl_if;

  logic       clr;        // Start of a message.
  logic       lane_wr;    // Qualified lane strobe.
  logic [1:0] lane_sel;
  logic       last_lane;
  logic       last_block;
  logic       fold;       // Accumulator takes block residue.

  modport fsm (
    output clr, lane_wr, fold,
    input  last_lane, last_block
  );

  modport cnt (
    input  clr, lane_wr,
    output lane_sel, last_lane, last_block
  );

  modport dp (
    input clr, lane_wr, lane_sel, last_lane, last_block, fold
  );

endinterface

// File: hdl/mod47_block_reducer.sv
`include "mod47_macros.svh"

module mod47_block_reducer (
  input  mod47_pkg::block_t   block,
  output mod47_pkg::residue_t residue
);

  import mod47_pkg::*;

  // 2^(6*(j+1)) mod 47 for digit position j+1.
  localparam logic [5:0] weight_tbl [16] = '{
    6'd17, 6'd7,  6'd25, 6'd2,
    6'd34, 6'd14, 6'd3,  6'd4,
    6'd21, 6'd28, 6'd6,  6'd8,
    6'd42, 6'd9,  6'd12, 6'd16
  };

  function automatic residue_t mul_mod(input logic [5:0] digit, input logic [5:0] weight);
    logic [11:0] prod;
    prod = 12'(digit) * 12'(weight);
    return residue_t'(prod % 12'(`MOD47_MODULUS));
  endfunction

  residue_t   mapped [16];
  logic [7:0] sum4 [4];
  logic [8:0] sum8 [2];
  logic [9:0] total;

  // ------------------------------------------------
  // Digit mapping
  // ------------------------------------------------
  always_comb
  begin
    for (int k = 0; k < 15; k++)
    begin
      mapped[k] = mul_mod(block.digits.mid[k], weight_tbl[k]);
    end
    mapped[15] = mul_mod({2'b00, block.digits.top}, weight_tbl[15]); // Only 4 bits wide.
  end

  // ------------------------------------------------
  // Adder tree
  // ------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      sum4[i] = 8'(mapped[4*i]) + 8'(mapped[4*i+1]) +
                8'(mapped[4*i+2]) + 8'(mapped[4*i+3]);
    end
    for (int j = 0; j < 2; j++)
    begin
      sum8[j] = 9'(sum4[2*j]) + 9'(sum4[2*j+1]);
    end
    total = 10'(sum8[0]) + 10'(sum8[1]) + 10'(block.digits.low); // At most 799.
  end

  assign residue = fold_mod47(total);

  always_comb
  begin
    assert (residue < 6'(`MOD47_MODULUS))
      else $error("Block residue %0d is not reduced.", residue);
  end

endmodule

// File: hdl/mod47_block_assembler.sv
`include "mod47_macros.svh"

module mod47_block_assembler (
  input  logic                     clk,
  input  logic                     arst_n,
  mod47_ctl_if.dp                  ctl,
  input  logic [`MOD47_LANE_W-1:0] lane_data,
  output mod47_pkg::block_t        block
);

  import mod47_pkg::*;

  block_t block_q;

  // Lane lands in the slot the counter points at.
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      block_q <= '0;
    end
    else if (ctl.lane_wr)
    begin
      block_q.lanes[ctl.lane_sel] <= lane_data;
    end
  end

  assign block = block_q;

endmodule

// File: hdl/mod47_residue_acc.sv
`include "mod47_macros.svh"

module mod47_residue_acc (
  input  logic                clk,
  input  logic                arst_n,
  mod47_ctl_if.dp             ctl,
  input  mod47_pkg::residue_t block_residue,
  output mod47_pkg::residue_t residue
);

  import mod47_pkg::*;

  residue_t   residue_q;
  logic [9:0] horner;

  // Shift the message left by one block and add the new one.
  assign horner = 10'(residue_q) * 10'(`MOD47_FOLD_MUL) + 10'(block_residue);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      residue_q <= '0;
    end
    else if (ctl.clr)
    begin
      residue_q <= '0;
    end
    else if (ctl.fold)
    begin
      residue_q <= fold_mod47(horner);
    end
  end

  assign residue = residue_q;

  a_residue_reduced : assert property (@(posedge clk) disable iff (!arst_n)
    ctl.fold |=> residue_q < 6'(`MOD47_MODULUS));

endmodule

// File: hdl/mod47_block_counter.sv
`include "mod47_macros.svh"

module mod47_block_counter (
  input  logic                    clk,
  input  logic                    arst_n,
  mod47_ctl_if.cnt                ctl,
  input  logic [`MOD47_CNT_W-1:0] num_blocks
);

  logic [`MOD47_CNT_W:0] blocks_left_q; // One bit extra to hold 256.
  logic [1:0]            lane_sel_q;

  assign ctl.lane_sel   = lane_sel_q;
  assign ctl.last_lane  = ctl.lane_wr && (lane_sel_q == 2'(`MOD47_LANES - 1));
  assign ctl.last_block = (blocks_left_q == (`MOD47_CNT_W+1)'(1));

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      blocks_left_q <= '0;
      lane_sel_q    <= '0;
    end
    else if (ctl.clr)
    begin
      if (num_blocks == '0)
        blocks_left_q <= {1'b1, {`MOD47_CNT_W{1'b0}}}; // Zero means 256.
      else
        blocks_left_q <= {1'b0, num_blocks};
      lane_sel_q <= '0;
    end
    else
    begin
      if (ctl.lane_wr)
        lane_sel_q <= lane_sel_q + 2'd1; // Wraps to lane 0.
      if (ctl.last_lane)
        blocks_left_q <= blocks_left_q - (`MOD47_CNT_W+1)'(1);
    end
  end

  a_no_extra_block : assert property (@(posedge clk) disable iff (!arst_n)
    ctl.last_lane |-> blocks_left_q != '0);

endmodule

// File: hdl/mod47_ctrl_fsm.sv
module mod47_ctrl_fsm (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     start,
  input  logic     lane_valid,
  mod47_ctl_if.fsm ctl,
  output logic     busy,
  output logic     done
);

  import mod47_pkg::*;

  fsm_state_t state_q;
  fsm_state_t state_d;
  logic       fold_q;
  logic       done_q;

  assign ctl.clr     = start && (state_q == st_idle);
  assign ctl.lane_wr = lane_valid && (state_q == st_collect);
  assign ctl.fold    = fold_q;
  assign busy        = (state_q != st_idle);
  assign done        = done_q;

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:
      begin
        if (start)
          state_d = st_collect;
      end
      st_collect:
      begin
        if (ctl.last_lane && ctl.last_block)
          state_d = st_finish;
      end
      st_finish:
      begin
        if (!fold_q)
          state_d = st_idle; // Final fold has landed.
      end
      default:
      begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q <= st_idle;
      fold_q  <= 1'b0;
      done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      fold_q  <= ctl.last_lane;
      done_q  <= (state_q == st_finish) && !fold_q;
    end
  end

  // A fold never lands once the FSM is back in idle.
  a_fold_while_busy : assert property (@(posedge clk) disable iff (!arst_n)
    ctl.fold |-> (state_q != st_idle));

endmodule

// File: hdl/mod47_checksum_top.sv
`include "mod47_macros.svh"

module mod47_checksum_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     start,
  input  logic [`MOD47_CNT_W-1:0]  num_blocks,
  input  logic [`MOD47_LANE_W-1:0] lane_data,
  input  logic                     lane_valid,
  output logic                     busy,
  output logic                     done,
  output logic [5:0]               residue
);

  import mod47_pkg::*;

  block_t   block;
  residue_t block_residue;

  mod47_ctl_if ctl ();

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  mod47_ctrl_fsm i_fsm (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .lane_valid (lane_valid),
    .ctl        (ctl.fsm),
    .busy       (busy),
    .done       (done)
  );

  mod47_block_counter i_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .ctl        (ctl.cnt),
    .num_blocks (num_blocks)
  );

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------
  mod47_block_assembler i_assembler (
    .clk       (clk),
    .arst_n    (arst_n),
    .ctl       (ctl.dp),
    .lane_data (lane_data),
    .block     (block)
  );

  mod47_block_reducer i_reducer (
    .block   (block),
    .residue (block_residue)
  );

  mod47_residue_acc i_acc (
    .clk           (clk),
    .arst_n        (arst_n),
    .ctl           (ctl.dp),
    .block_residue (block_residue),
    .residue       (residue)
  );

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period.
  end

  initial
  begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    #5 arst_n = 1'b1;
  end

endmodule

// File: sim/tb_mod47_checksum.sv
module tb_mod47_checksum;

  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        arst_n;
  logic        start;
  logic [7:0]  num_blocks;
  logic [24:0] lane_data;
  logic        lane_valid;
  logic        busy;
  logic        done;
  logic [5:0]  residue;

  integer      seed;
  int          pass_cnt;
  int          fail_cnt;
  int          test_errs;
  int          last_residue;
  bit          timed_out;
  string       name;
  int          gaps;
  int          nblocks;
  int          nlisted;
  int          expected;
  logic [24:0] lanes [32];

  tb_clock_gen i_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  mod47_checksum_top i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .num_blocks (num_blocks),
    .lane_data  (lane_data),
    .lane_valid (lane_valid),
    .busy       (busy),
    .done       (done),
    .residue    (residue)
  );

  // Inputs change and outputs are read 5 ns after the edge.
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic check_equal(input string what, input int exp, input int act);
    assert (exp == act)
      else
      begin
        $display("Fail %s %s expected %0d actual %0d", name, what, exp, act);
        test_errs++;
      end
  endtask

  task automatic finish_test();
    if (test_errs == 0)
    begin
      $display("%s: pass", name);
      pass_cnt++;
    end
    else
    begin
      $display("%s: FAIL with %0d errors", name, test_errs);
      fail_cnt++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $finish;
  endtask

  // ------------------------------------------------
  // One message from the golden file
  // ------------------------------------------------
  task automatic run_message();
    int gap;
    int n;
    test_errs = 0;

    // Stray strobes while idle must neither fold nor start a message.
    for (int s = 0; s < 4; s++)
    begin
      lane_valid = 1'b1;
      lane_data  = 25'h1abcdef;
      next_cycle();
    end
    lane_valid = 1'b0;
    next_cycle();
    check_equal("busy while idle", 0, int'(busy));
    check_equal("held residue", last_residue, int'(residue));

    start      = 1'b1;
    num_blocks = 8'(nblocks); // 256 wraps to 0.
    next_cycle();
    start      = 1'b0;
    num_blocks = 8'd1;
    check_equal("busy after start", 1, int'(busy));
    check_equal("residue after start", 0, int'(residue));

    for (int b = 0; b < nblocks; b++)
    begin
      for (int l = 0; l < 4; l++)
      begin
        if (gaps != 0)
        begin
          gap = int'($unsigned($random(seed)) % 3);
          repeat (gap) next_cycle();
        end
        check_equal("busy while collecting", 1, int'(busy));
        lane_valid = 1'b1;
        lane_data  = lanes[(b % nlisted) * 4 + l];
        if (b == 0 && l == 1)
          start = 1'b1; // Ignored while busy.
        next_cycle();
        lane_valid = 1'b0;
        start      = 1'b0;
      end
    end

    // The last strobe was sampled at the edge just passed.
    n = 1;
    while (!done && n < 2000)
    begin
      check_equal("busy before done", 1, int'(busy));
      next_cycle();
      n++;
    end
    if (!done)
    begin
      $display("Test %s: done never came within 2000 cycles.", name);
      test_errs++;
      timed_out = 1'b1;
    end
    else
    begin
      check_equal("done latency", 3, n);
      check_equal("busy at done", 0, int'(busy));
      check_equal("residue", expected, int'(residue));
      next_cycle();
      check_equal("done pulse width", 0, int'(done));
      repeat (2) next_cycle();
      check_equal("residue hold", expected, int'(residue));
      last_residue = expected;
    end
    finish_test();
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial
  begin
    int    fd;
    int    r;
    int    n;
    string line;
    start        = 1'b0;
    num_blocks   = 8'd0;
    lane_data    = '0;
    lane_valid   = 1'b0;
    seed         = 32'h5265;
    pass_cnt     = 0;
    fail_cnt     = 0;
    last_residue = 0;
    timed_out    = 1'b0;

    n = 0;
    while (arst_n !== 1'b1 && n < 100)
    begin
      next_cycle();
      n++;
    end
    if (arst_n !== 1'b1)
      abort_run("Reset was never released.");
    else
    begin
      name      = "reset";
      test_errs = 0;
      next_cycle();
      check_equal("busy", 0, int'(busy));
      check_equal("done", 0, int'(done));
      check_equal("residue", 0, int'(residue));
      finish_test();

      fd = $fopen("sim/mod47_golden.txt", "r");
      if (fd == 0)
        abort_run("Could not open the golden file sim/mod47_golden.txt.");
      else
      begin
        r = $fgets(line, fd); // Two column description lines.
        r = $fgets(line, fd);

        while (!$feof(fd) && !timed_out)
        begin
          r = $fscanf(fd, " %s %d %d %d", name, gaps, nblocks, nlisted);
          if (r != 4)
            break;
          for (int i = 0; i < nlisted * 4; i++)
          begin
            r = $fscanf(fd, " %h", lanes[i]);
          end
          r = $fscanf(fd, " %d", expected);
          run_message();
        end
        $fclose(fd);

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 1)
          $display("Simulation passed");
        else
          $display("Simulation failed");
        $finish;
      end
    end
  end

endmodule

// File: sim/mod47_golden.txt
# name gaps num_blocks listed_blocks, then each listed block as four hex lanes, lane 0 first,
# then the expected residue in decimal. Listed blocks repeat until num_blocks is reached.
zero 0 1 1
0000000 0000000 0000000 0000000
0
val46 0 1 1
000002e 0000000 0000000 0000000
46
val47 0 1 1
000002f 0000000 0000000 0000000
0
pow99 0 1 1
0000000 0000000 0000000 1000000
34
top_digit 0 1 1
0000000 0000000 0000000 1e00000
5
all_ones 0 1 1
1ffffff 1ffffff 1ffffff 1ffffff
20
mixed 1 1 1
00003e8 0000001 0000001 0000001
3
two_blk 0 2 2
0000001 0000000 0000000 0000000
0000002 0000000 0000000 0000000
23
three_blk 0 3 3
1ffffff 1ffffff 1ffffff 1ffffff
000002e 0000000 0000000 0000000
0000000 0000000 0000000 1000000
44
three_blk_gap 1 3 3
1ffffff 1ffffff 1ffffff 1ffffff
000002e 0000000 0000000 0000000
0000000 0000000 0000000 1000000
44
four_blk 1 4 4
0000000 0000000 0000000 0000001
0000000 0000000 0000001 0000000
0000000 0000001 0000000 0000000
0000005 0000000 0000000 0000000
35
six_blk 0 6 1
0000001 0000000 0000000 0000000
26
blk256 0 256 1
0000001 0000000 0000000 0000000
40

// File: mod47_checksum.f
+incdir+hdl
hdl/mod47_pkg.sv
hdl/mod47_ctl_if.sv
hdl/mod47_block_reducer.sv
hdl/mod47_block_assembler.sv
hdl/mod47_residue_acc.sv
hdl/mod47_block_counter.sv
hdl/mod47_ctrl_fsm.sv
hdl/mod47_checksum_top.sv
sim/tb_clock_gen.sv
sim/tb_mod47_checksum.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mod47_checksum testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f mod47_checksum.f \
  --top-module tb_mod47_checksum \
  -o sim_mod47 > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_mod47 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  exit 0
fi
exit 1
